/* compile.f */
median_pkg.sv
window_if.sv
window_fifo.sv
column_sort.sv
median_select.sv
median_top.sv
tb_median_checker.sv
tb_median_top.sv

/* Makefile */
# Verilator build and run for the median filter testbench

VERILATOR ?= verilator
TOP       ?= tb_median_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

/* tb_median_top.sv */
`timescale 1ns/1ps

module tb_median_top;
    import median_pkg::*;

    localparam int FIFO_DEPTH  = 4;
    localparam int OUT_CREDITS = 2;
    localparam int NUM_WIN     = 60;
    localparam int HOLD_AFTER  = 15;
    localparam int HOLD_CYCLES = 30;
    localparam int LIMIT       = NUM_WIN * 20 + 200;

    logic    i_clk;
    logic    i_rst;
    logic    i_valid;
    logic    i_credit;
    window_t pix;
    logic    o_credit;
    logic    o_valid;
    pixel_t  o_median;

    logic    hold;
    logic    done;
    integer  seed;
    int      total_sent = 0;
    int      credits_back = 0;
    int      results_seen = 0;
    int      credits_given = 0;
    int      err_count;
    int      accept_count;
    int      result_count;
    int      return_count;

    median_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_median_top (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_valid  (i_valid),
        .i_pix_00 (pix[0][0]),
        .i_pix_01 (pix[0][1]),
        .i_pix_02 (pix[0][2]),
        .i_pix_10 (pix[1][0]),
        .i_pix_11 (pix[1][1]),
        .i_pix_12 (pix[1][2]),
        .i_pix_20 (pix[2][0]),
        .i_pix_21 (pix[2][1]),
        .i_pix_22 (pix[2][2]),
        .i_credit (i_credit),
        .o_credit (o_credit),
        .o_valid  (o_valid),
        .o_median (o_median)
    );

    tb_median_checker #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_checker (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_window       (pix),
        .i_credit       (i_credit),
        .i_out_credit   (o_credit),
        .i_out_valid    (o_valid),
        .i_out_median   (o_median),
        .i_hold         (hold),
        .i_done         (done),
        .o_err_count    (err_count),
        .o_accept_count (accept_count),
        .o_result_count (result_count),
        .o_return_count (return_count)
    );

    initial i_clk = 1'b0;
    always #20 i_clk = ~i_clk;

    // Corner windows first, then random pixels
    function automatic window_t build_window(input int idx);
        window_t w;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                case (idx)
                    0:       w[r][c] = 8'h5a;
                    1:       w[r][c] = pixel_t'(10 + 25 * (r*3 + c));
                    2:       w[r][c] = pixel_t'(250 - 25 * (r*3 + c));
                    default: w[r][c] = pixel_t'($random(seed));
                endcase
            end
        end
        return w;
    endfunction

    // Input credits come back on o_credit, results on o_valid
    always @(posedge i_clk) begin
        if (!i_rst && o_credit === 1'b1) begin
            credits_back++;
        end
        if (!i_rst && o_valid === 1'b1) begin
            results_seen++;
        end
    end

    ////////////////////////////////////////
    // Upstream and downstream
    ////////////////////////////////////////
    initial begin : upstream
        i_valid = 1'b0;
        pix     = '0;
        seed    = 32'hdbeefc53;
        @(negedge i_rst);
        while (total_sent < NUM_WIN) begin
            @(posedge i_clk);
            #2;
            if (total_sent - credits_back < FIFO_DEPTH) begin
                pix     = build_window(total_sent);
                i_valid = 1'b1;
                total_sent++;
            end else begin
                i_valid = 1'b0;
            end
        end
        @(posedge i_clk);
        #2;
        i_valid = 1'b0;
    end

    // Prompt credit return, then a withheld stretch, then prompt again
    initial begin : downstream
        int   hold_left;
        logic hold_done;
        i_credit  = 1'b0;
        hold      = 1'b0;
        hold_left = 0;
        hold_done = 1'b0;
        @(negedge i_rst);
        forever begin
            @(posedge i_clk);
            #2;
            if (hold) begin
                hold_left--;
                if (hold_left == 0) begin
                    hold      = 1'b0;
                    hold_done = 1'b1;
                end
            end else if (!hold_done && results_seen >= HOLD_AFTER) begin
                hold      = 1'b1;
                hold_left = HOLD_CYCLES;
            end
            i_credit = !hold && (credits_given < results_seen);
            if (i_credit) begin
                credits_given++;
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT) @(posedge i_clk);
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        i_rst = 1'b1;
        done  = 1'b0;
        repeat (16) @(posedge i_clk);
        #2;
        i_rst = 1'b0;
        wait (total_sent == NUM_WIN);
        wait (results_seen == NUM_WIN && credits_given == NUM_WIN);
        repeat (4) @(posedge i_clk);
        #2;
        done = 1'b1;
        repeat (2) @(posedge i_clk);
        #1;
        $display("Summary: %0d accepted, %0d results, %0d input credits, %0d errors",
                 accept_count, result_count, return_count, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb_median_checker.sv */
`timescale 1ns/1ps

module tb_median_checker #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  median_pkg::window_t i_window,
    input  logic                i_credit,
    input  logic                i_out_credit,
    input  logic                i_out_valid,
    input  median_pkg::pixel_t  i_out_median,
    input  logic                i_hold,
    input  logic                i_done,
    output int                  o_err_count,
    output int                  o_accept_count,
    output int                  o_result_count,
    output int                  o_return_count
);
    import median_pkg::*;

    pixel_t exp_q[$];
    int     err_count = 0;
    int     accept_count = 0;
    int     result_count = 0;
    int     credit_in_count = 0;
    int     credit_out_count = 0;
    int     edge_count = 0;
    int     hold_cycles = 0;
    int     release_wait = 0;
    logic   rst_q = 1'b1;
    logic   hold_q = 1'b0;
    logic   done_q = 1'b0;
    logic   wait_valid = 1'b0;
    logic   wait_credit = 1'b0;

    assign o_err_count    = err_count;
    assign o_accept_count = accept_count;
    assign o_result_count = result_count;
    assign o_return_count = credit_out_count;

    task automatic value_error(input string name, input int got, input int want);
        err_count++;
        $display("ERROR: %s = 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
    endtask

    task automatic rule_error(input string what);
        err_count++;
        $display("Check failed at %0t: %s", $time, what);
    endtask

    // Fifth smallest of the nine by insertion sort
    function automatic pixel_t median_of_nine(input window_t w);
        pixel_t v[9];
        pixel_t t;
        int     k;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                v[r*3 + c] = w[r][c];
            end
        end
        for (int i = 1; i < 9; i++) begin
            t = v[i];
            k = i;
            while (k > 0 && v[k-1] > t) begin
                v[k] = v[k-1];
                k--;
            end
            v[k] = t;
        end
        return v[4];
    endfunction

    ////////////////////////////////////////
    // Scoreboard
    ////////////////////////////////////////
    always @(posedge i_clk) begin : scoreboard
        pixel_t want;
        // Outputs quiet in reset and on the first edge after release
        if (edge_count > 0 && (i_rst || rst_q)) begin
            assert (!i_out_valid && !i_out_credit)
                else rule_error("o_valid or o_credit high during or right after reset");
        end
        rst_q = i_rst;
        edge_count++;
        if (!i_rst) begin
            if (i_valid) begin
                exp_q.push_back(median_of_nine(i_window));
                accept_count++;
            end
            if (i_out_valid) begin
                assert (exp_q.size() > 0)
                    else rule_error("result appeared with no accepted window left");
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    assert (i_out_median == want)
                        else value_error("o_median", int'(i_out_median), int'(want));
                end
                result_count++;
            end
            if (i_credit) begin
                credit_in_count++;
            end
            if (i_out_credit) begin
                credit_out_count++;
            end
        end
    end

    // Results held downstream never exceed the slots it granted
    a_outstanding: assert property (
        @(posedge i_clk) disable iff (i_rst) (result_count - credit_in_count) <= OUT_CREDITS
    ) else rule_error("more results outstanding than output credits");

    ////////////////////////////////////////
    // Back-pressure and recovery
    ////////////////////////////////////////
    always @(posedge i_clk) begin : backpressure
        if (i_hold) begin
            // A few cycles to drain what was already issued
            if (hold_cycles >= 10) begin
                assert (!i_out_valid)
                    else rule_error("o_valid still active with output credits withheld");
                assert (!i_out_credit)
                    else rule_error("o_credit still active with output credits withheld");
            end
            hold_cycles++;
        end
        if (hold_q && !i_hold) begin
            wait_valid   = 1'b1;
            wait_credit  = 1'b1;
            release_wait = 0;
        end
        if (wait_valid || wait_credit) begin
            release_wait++;
            if (i_out_valid) begin
                wait_valid = 1'b0;
            end
            if (i_out_credit) begin
                wait_credit = 1'b0;
            end
            assert (release_wait < 20 || !(wait_valid || wait_credit)) else begin
                rule_error("no o_valid or o_credit after output credits were released");
                wait_valid  = 1'b0;
                wait_credit = 1'b0;
            end
        end
        hold_q = i_hold;
    end

    always @(posedge i_clk) begin : end_of_run
        if (i_done && !done_q) begin
            assert (result_count == accept_count)
                else value_error("o_valid count", result_count, accept_count);
            assert (exp_q.size() == 0)
                else rule_error("accepted windows never produced a result");
            assert (credit_out_count == accept_count)
                else value_error("o_credit count", credit_out_count, accept_count);
            assert (hold_cycles > 10)
                else rule_error("output credits were never withheld");
        end
        done_q = i_done;
    end

endmodule

/* median_top.sv */
`timescale 1ns/1ps

module median_top #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic               i_clk,
    input  logic               i_rst,
    // Upstream window, row then column
    input  logic               i_valid,
    input  median_pkg::pixel_t i_pix_00,
    input  median_pkg::pixel_t i_pix_01,
    input  median_pkg::pixel_t i_pix_02,
    input  median_pkg::pixel_t i_pix_10,
    input  median_pkg::pixel_t i_pix_11,
    input  median_pkg::pixel_t i_pix_12,
    input  median_pkg::pixel_t i_pix_20,
    input  median_pkg::pixel_t i_pix_21,
    input  median_pkg::pixel_t i_pix_22,
    // Credit exchange
    input  logic               i_credit,
    output logic               o_credit,
    // Result
    output logic               o_valid,
    output median_pkg::pixel_t o_median
);
    import median_pkg::*;

    window_t in_win;

    window_if raw ();
    window_if sorted ();

    assign in_win[0][0] = i_pix_00;
    assign in_win[0][1] = i_pix_01;
    assign in_win[0][2] = i_pix_02;
    assign in_win[1][0] = i_pix_10;
    assign in_win[1][1] = i_pix_11;
    assign in_win[1][2] = i_pix_12;
    assign in_win[2][0] = i_pix_20;
    assign in_win[2][1] = i_pix_21;
    assign in_win[2][2] = i_pix_22;

    ////////////////////////////////////////
    // Window buffer and credit control
    ////////////////////////////////////////
    window_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_window_fifo (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_valid  (i_valid),
        .i_window (in_win),
        .i_credit (i_credit),
        .o_credit (o_credit),
        .raw      (raw.producer)
    );

    ////////////////////////////////////////
    // Column sort, one sorter per column
    ////////////////////////////////////////
    for (genvar c = 0; c < WIN; c++) begin : g_col
        column_sort #(
            .COL (c)
        ) u_col (
            .i_clk  (i_clk),
            .i_rst  (i_rst),
            .raw    (raw.consumer),
            .sorted (sorted.producer)
        );
    end

    median_select u_median_select (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .sorted   (sorted.consumer),
        .o_valid  (o_valid),
        .o_median (o_median)
    );

endmodule

/* median_select.sv */
`timescale 1ns/1ps

module median_select (
    input  logic               i_clk,
    input  logic               i_rst,
    window_if.consumer         sorted,
    output logic               o_valid,
    output median_pkg::pixel_t o_median
);
    import median_pkg::*;

    window_t rows_s;
    line_t   diag;
    line_t   diag_s;

    ////////////////////////////////////////
    // Row sort
    ////////////////////////////////////////
    // Columns are already ordered, so after this every row
    // and every column of rows_s is ascending
    always_comb begin
        for (int r = 0; r < WIN; r++) begin
            rows_s[r] = sort3(sorted.win[r]);
        end
    end

    ////////////////////////////////////////
    // Anti-diagonal
    ////////////////////////////////////////
    // Largest of row 0, middle of row 1, smallest of row 2
    always_comb begin
        diag[0] = rows_s[0][2];
        diag[1] = rows_s[1][1];
        diag[2] = rows_s[2][0];
        diag_s  = sort3(diag);
    end

    // Middle of the diagonal is the median of all nine
    always_ff @(posedge i_clk) begin
        if (sorted.valid) begin
            o_median <= diag_s[1];
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= sorted.valid;
        end
    end

    // Pipeline is empty when reset lets go, so nothing comes out
    // on the release edge or the one after it
    a_quiet_after_reset: assert property (
        @(posedge i_clk) $fell(i_rst) |-> !o_valid ##1 !o_valid
    ) else $error("median_select: o_valid high around reset release");

endmodule

/* column_sort.sv */
`timescale 1ns/1ps

module column_sort #(
    parameter int COL = 0
) (
    input  logic       i_clk,
    input  logic       i_rst,
    window_if.consumer raw,
    window_if.producer sorted
);
    import median_pkg::*;

    line_t col_in;
    line_t col_q;

    // Gather column COL, top row first
    always_comb begin
        for (int r = 0; r < WIN; r++) begin
            col_in[r] = raw.win[r][COL];
        end
    end

    always_ff @(posedge i_clk) begin
        if (raw.valid) begin
            col_q <= sort3(col_in);
        end
    end

    // Smallest value ends up in row 0
    for (genvar r = 0; r < WIN; r++) begin : g_row
        assign sorted.win[r][COL] = col_q[r];
    end

    // Column 0 carries the window valid for the whole stage
    if (COL == 0) begin : g_valid
        logic valid_q;

        always_ff @(posedge i_clk or posedge i_rst) begin
            if (i_rst) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= raw.valid;
            end
        end

        assign sorted.valid = valid_q;
    end

endmodule

/* window_fifo.sv */
`timescale 1ns/1ps

module window_fifo #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  median_pkg::window_t i_window,
    input  logic                i_credit,
    output logic                o_credit,
    window_if.producer          raw
);
    import median_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(FIFO_DEPTH);
    localparam logic [CRD_W-1:0] INIT_CRED = CRD_W'(OUT_CREDITS);

    window_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credit_cnt;
    logic             issue;
    logic             issue_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == LAST_PTR) ? '0 : p + 1'b1;
    endfunction

    // Downstream slot must be free before a window leaves
    assign issue = (count != '0) && (credit_cnt != '0);

    ////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            mem[wr_ptr] <= i_window;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({i_valid, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////
    // Output credit counter
    ////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            credit_cnt <= INIT_CRED;
        end else begin
            case ({issue, i_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Issued window and returned input credit share one pulse
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= issue;
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            raw.win <= mem[rd_ptr];
        end
    end

    assign raw.valid = issue_q;
    assign o_credit  = issue_q;

    // Upstream may only write while it holds an input credit
    a_no_write_full: assert property (
        @(posedge i_clk) disable iff (i_rst) i_valid |-> (count != FULL_CNT)
    ) else $error("window_fifo: write while FIFO full");

    // Downstream never returns more slots than it was granted
    a_credit_bound: assert property (
        @(posedge i_clk) disable iff (i_rst) credit_cnt <= INIT_CRED
    ) else $error("window_fifo: output credit counter above grant");

endmodule

/* window_if.sv */
`timescale 1ns/1ps

interface window_if;
    import median_pkg::*;

    // Window qualifier, one cycle per window
    logic    valid;

    // Nine pixels, [row][col]
    window_t win;

    // Stage that registers the window
    modport producer (
        output valid,
        output win
    );

    // Stage that reads it on the next edge
    modport consumer (
        input valid,
        input win
    );

endinterface

/* median_pkg.sv */
package median_pkg;

    ////////////////////////////////////////
    // Pixel and window geometry
    ////////////////////////////////////////
    localparam int PIX_W = 8;
    localparam int WIN   = 3;

    typedef logic [PIX_W-1:0] pixel_t;

    // One row or one column of the window, index 0 first
    typedef pixel_t [WIN-1:0] line_t;

    // Indexed [row][col]
    typedef line_t [WIN-1:0] window_t;

    ////////////////////////////////////////
    // Three-value sorting network
    ////////////////////////////////////////
    // Ascending, smallest lands in index 0
    function automatic line_t sort3(input line_t v);
        pixel_t lo;
        pixel_t hi;
        pixel_t mid;
        pixel_t top;
        line_t  res;
        // Order the first pair
        lo  = (v[0] < v[1]) ? v[0] : v[1];
        hi  = (v[0] < v[1]) ? v[1] : v[0];
        // Larger of the pair against the third value
        top = (hi < v[2]) ? v[2] : hi;
        mid = (hi < v[2]) ? hi : v[2];
        // Final exchange of the two lower values
        res[0] = (lo < mid) ? lo : mid;
        res[1] = (lo < mid) ? mid : lo;
        res[2] = top;
        return res;
    endfunction

endpackage
